// File: tb.f
rtl/phx_pkg.sv
rtl/fp_decomp16.sv
rtl/fp_compare16.sv
rtl/phx_int_path16.sv
rtl/phx_fp_path16.sv
rtl/phx_alu16.sv
rtl/phx_alu16_apb.sv
tb/tb_phx_alu16.sv

// File: Bender.yml
package:
  name: phx_alu16

sources:
  # RTL in compile order
  - rtl/phx_pkg.sv
  - rtl/fp_decomp16.sv
  - rtl/fp_compare16.sv
  - rtl/phx_int_path16.sv
  - rtl/phx_fp_path16.sv
  - rtl/phx_alu16.sv
  - rtl/phx_alu16_apb.sv

  # testbench
  - target: test
    files:
      - tb/tb_phx_alu16.sv

// File: tb/tb_phx_alu16.sv
`timescale 1ns/1ps
`default_nettype none

module tb_phx_alu16 import phx_pkg::*;
();

	localparam int DRV_DLY = 10;		// input drive delay after the rising edge
	localparam int MAX_CYC = 4000;		// all tests take about 2900 cycles

	logic              clk_i;
	logic              rst_i;
	logic              psel_i, penable_i, pwrite_i;
	logic [APB_AW-1:0] paddr_i;
	logic [WORD_W-1:0] pwdata_i;
	logic [WORD_W-1:0] prdata_o;
	logic              pslverr_o;

	integer            seed;
	int                test_errs, pass_cnt, fail_cnt;
	logic [15:0]       cur_a, cur_b, cur_imm;	// operand shadows for the model

	// register and immediate forms of the arithmetic ops
	logic [15:0] arith_ir [10] = '{{OP_R2, FN_ADD, 4'h0}, {OP_R2, FN_SUB, 4'h0},
		{OP_R2, FN_AND, 4'h0}, {OP_R2, FN_OR, 4'h0}, {OP_R2, FN_XOR, 4'h0},
		{OP_ADDI, 10'h0}, {OP_SUBFI, 10'h0}, {OP_ANDI, 10'h0}, {OP_ORI, 10'h0},
		{OP_XORI, 10'h0}};
	logic [15:0] half_ops [6] = '{{OP_R2, FN_R1, SB_FABS}, {OP_R2, FN_R1, SB_FNABS},
		{OP_R2, FN_R1, SB_FNEG}, {OP_R2, FN_R1, SB_FSIGN}, {OP_R2, FN_R1, SB_FFINITE},
		{OP_R2, FN_R1, SB_FCLASS}};
	logic [15:0] edges [4] = '{16'h0000, 16'h7FFF, 16'h8000, 16'hFFFF};
	logic [15:0] clz_vals [8] = '{16'h0000, 16'h0001, 16'h8000, 16'h00F0, 16'hFFFF,
		16'h0100, 16'h0080, 16'h007F};
	// +-0, +-subnormal, normals, +-inf, nans
	logic [15:0] half_vals [12] = '{16'h0000, 16'h8000, 16'h0001, 16'h8001, 16'h03FF,
		16'h3C00, 16'hC500, 16'h7C00, 16'hFC00, 16'h7E00, 16'h7C01, 16'hFE00};
	logic [15:0] fa [11] = '{16'h3C00, 16'h4000, 16'hC000, 16'hC000, 16'h0000, 16'h8000,
		16'h3C00, 16'h7E00, 16'h3C00, 16'h7C00, 16'h0001};
	logic [15:0] fb [11] = '{16'h4000, 16'h3C00, 16'h3C00, 16'hC400, 16'h8000, 16'h0000,
		16'h3C00, 16'h3C00, 16'h7C01, 16'hFC00, 16'h0000};

	phx_alu16_apb i_phx_alu16_apb
	(
		.clk_i(clk_i),
		.rst_i(rst_i),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.paddr_i(paddr_i),
		.pwdata_i(pwdata_i),
		.prdata_o(prdata_o),
		.pslverr_o(pslverr_o)
	);

	initial
	begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;		// 100 ns period
	end

	// ============================================================
	// reference model
	// ============================================================
	function automatic logic [15:0] int_cmp_vec(input logic [15:0] a, input logic [15:0] b);
		int sa, sb, ua, ub;
		logic [15:0] v;
		sa = $signed(a);
		sb = $signed(b);
		ua = a;
		ub = b;
		v = '0;
		v[0] = ua == ub;
		v[1] = sa < sb;
		v[2] = sa <= sb;
		v[5] = ua < ub;
		v[6] = ua <= ub;
		v[8] = ua != ub;
		v[9] = sa >= sb;
		v[10] = sa > sb;
		v[13] = ua >= ub;
		v[14] = ua > ub;
		return v;
	endfunction

	function automatic bit is_nan(input logic [15:0] x);
		return (x[14:10] == 5'h1F) && (x[9:0] != 10'h0);
	endfunction

	// ordering key, -0 and +0 both map to 0
	function automatic logic [15:0] half_cmp_vec(input logic [15:0] a, input logic [15:0] b);
		int ka, kb;
		bit unord;
		logic [15:0] v;
		ka = a[15] ? -int'(a[14:0]) : int'(a[14:0]);
		kb = b[15] ? -int'(b[14:0]) : int'(b[14:0]);
		unord = is_nan(a) || is_nan(b);
		v = '0;
		v[4] = unord;
		v[5] = unord || (ka != kb);
		v[11] = a[14:0] >= b[14:0];		// magnitude, ordered or not
		v[12] = !unord;
		if (!unord)
		begin
			v[0] = ka == kb;
			v[1] = ka < kb;
			v[2] = ka <= kb;
			v[9] = ka >= kb;
			v[10] = ka > kb;
		end
		return v;
	endfunction

	function automatic logic [15:0] half_class(input logic [15:0] a);
		logic [15:0] v;
		v = '0;
		v[15] = a[15];
		v[1] = a[15];
		v[6] = !a[15];
		if (a[14:10] == 5'h1F)
		begin
			if (a[9:0] == 0)
				v[a[15] ? 0 : 7] = 1'b1;		// infinity
			else
				v[a[9] ? 9 : 8] = 1'b1;			// quiet or signalling nan
		end
		else if (a[14:10] == 5'h00)
			v[a[15] ? (a[9:0] == 0 ? 3 : 2) : (a[9:0] == 0 ? 4 : 5)] = 1'b1;
		return v;
	endfunction

	function automatic logic [15:0] count_lz(input logic [15:0] a);
		int n;
		n = 0;
		while (n < 16 && a[15-n] == 1'b0)
			n++;
		return n;
	endfunction

	// returns {illegal, result}
	function automatic logic [16:0] ref_model(input logic [15:0] ir, input logic [15:0] a,
		input logic [15:0] b, input logic [15:0] imm);
		logic [15:0] r;
		logic ill;
		r = '0;
		ill = 1'b0;
		case (ir[15:10])
		OP_R2:
			if (ir[9:4] == FN_R1)
			begin
				case (ir[3:0])
				SB_CNTLZ:	r = count_lz(a);
				SB_SEXTB:	r = {{8{a[7]}}, a[7:0]};
				SB_FABS:	r = a & 16'h7FFF;
				SB_FNABS:	r = a | 16'h8000;
				SB_FNEG:	r = a ^ 16'h8000;
				SB_FSIGN:	r = (a[14:0] == 0) ? 16'h0 : (a[15] ? HALF_NEG_ONE : HALF_POS_ONE);
				SB_FFINITE:	r = (a[14:10] != 5'h1F);
				SB_FCLASS:	r = half_class(a);
				default:	ill = 1'b1;
				endcase
			end
			else
			begin
				case (ir[9:4])
				FN_ADD:		r = a + b;
				FN_SUB:		r = a - b;
				FN_AND:		r = a & b;
				FN_OR:		r = a | b;
				FN_XOR:		r = a ^ b;
				default:	ill = 1'b1;
				endcase
			end
		OP_ADDI:	r = a + imm;
		OP_SUBFI:	r = imm - a;
		OP_ANDI:	r = a & imm;
		OP_ORI:		r = a | imm;
		OP_XORI:	r = a ^ imm;
		OP_CMP:		r = int_cmp_vec(a, b);
		OP_CMPI:	r = int_cmp_vec(a, imm);
		OP_FCMP:	r = half_cmp_vec(a, b);
		OP_FCMPI:	r = half_cmp_vec(a, imm);
		default:	ill = 1'b1;
		endcase
		if (ill)
			r = '0;			// illegal gives zero
		return {ill, r};
	endfunction

	// ============================================================
	// apb transfers and checks
	// ============================================================
	task automatic check_value(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		a_match : assert (got === exp)
		else
		begin
			$display("ERR %0t: %s, got %h expected %h", $time, what, got, exp);
			test_errs++;
		end
	endtask

	// setup cycle then access cycle, sampled at the access falling edge
	task automatic apb_write(input logic [7:0] addr, input logic [15:0] data,
		output logic err);
		psel_i = 1'b1;
		penable_i = 1'b0;
		pwrite_i = 1'b1;
		paddr_i = addr;
		pwdata_i = data;
		@(posedge clk_i);
		#DRV_DLY;
		penable_i = 1'b1;
		@(negedge clk_i);
		err = pslverr_o;
		@(posedge clk_i);
		#DRV_DLY;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [15:0] data,
		output logic err);
		psel_i = 1'b1;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = addr;
		@(posedge clk_i);
		#DRV_DLY;
		penable_i = 1'b1;
		@(negedge clk_i);
		data = prdata_o;			// prdata valid in access
		err = pslverr_o;
		@(posedge clk_i);
		#DRV_DLY;
		psel_i = 1'b0;
		penable_i = 1'b0;
	endtask

	task automatic set_operands(input logic [15:0] a, input logic [15:0] b,
		input logic [15:0] imm);
		logic err;
		apb_write(REG_A, a, err);
		check_value("pslverr on A write", err, 16'h0);
		apb_write(REG_B, b, err);
		check_value("pslverr on B write", err, 16'h0);
		apb_write(REG_IMM, imm, err);
		check_value("pslverr on IMM write", err, 16'h0);
		cur_a = a;
		cur_b = b;
		cur_imm = imm;
	endtask

	// launch, then result, and status if asked
	task automatic exec_check(input logic [15:0] ir, input bit chk_status);
		logic [16:0] exp;
		logic [15:0] got;
		logic err;
		exp = ref_model(ir, cur_a, cur_b, cur_imm);
		apb_write(REG_IR, ir, err);
		check_value("pslverr on IR write", err, 16'h0);
		apb_read(REG_RESULT, got, err);
		check_value($sformatf("result ir %h a %h b %h imm %h", ir, cur_a, cur_b, cur_imm),
			got, exp[15:0]);
		if (chk_status)
		begin
			apb_read(REG_STATUS, got, err);
			check_value($sformatf("status ir %h", ir), got, {15'h0, exp[16]});
		end
	endtask

	task automatic run_op(input logic [15:0] a, input logic [15:0] b, input logic [15:0] imm,
		input logic [15:0] ir);
		set_operands(a, b, imm);
		exec_check(ir, 1'b1);
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0)
		begin
			pass_cnt++;
			$display("test %-10s ok", name);
		end
		else
		begin
			fail_cnt++;
			$display("test %-10s failed with %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	// ============================================================
	// stimulus
	// ============================================================
	initial
	begin
		logic [15:0] ra, rb, ri, got;
		logic err;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = '0;
		pwdata_i = '0;
		rst_i = 1'b1;
		seed = 41;
		test_errs = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		repeat (8) @(posedge clk_i);
		#DRV_DLY;
		rst_i = 1'b0;

		// everything comes out of reset cleared
		apb_read(REG_RESULT, got, err);
		check_value("result after reset", got, 16'h0);
		apb_read(REG_A, got, err);
		check_value("A after reset", got, 16'h0);
		finish_test("reset");

		for (int n = 0; n < 40; n++)
		begin
			ra = $random(seed);
			rb = $random(seed);
			ri = $random(seed);
			set_operands(ra, rb, ri);
			foreach (arith_ir[k])
				exec_check(arith_ir[k], k == 0);
		end
		finish_test("int_arith");

		foreach (edges[i])
			foreach (edges[j])
			begin
				set_operands(edges[i], edges[j], edges[j] ^ 16'h0001);
				exec_check({OP_CMP, 10'h0}, 1'b0);
				exec_check({OP_CMPI, 10'h0}, j == 0);
			end
		for (int n = 0; n < 8; n++)
		begin
			ra = $random(seed);
			rb = $random(seed);
			ri = (n < 2) ? ra : $random(seed);	// a few equal immediates
			set_operands(ra, rb, ri);
			exec_check({OP_CMP, 10'h0}, 1'b0);
			exec_check({OP_CMPI, 10'h0}, 1'b0);
		end
		foreach (clz_vals[i])
		begin
			set_operands(clz_vals[i], 16'h0, 16'h0);
			exec_check({OP_R2, FN_R1, SB_CNTLZ}, 1'b0);
			exec_check({OP_R2, FN_R1, SB_SEXTB}, 1'b0);
		end
		finish_test("int_cmp");

		foreach (half_vals[i])
		begin
			set_operands(half_vals[i], 16'h0, 16'h0);
			foreach (half_ops[k])
				exec_check(half_ops[k], k == 5);
		end
		finish_test("half_ops");

		// immediate is b with the sign flipped
		foreach (fa[i])
		begin
			set_operands(fa[i], fb[i], fb[i] ^ 16'h8000);
			exec_check({OP_FCMP, 10'h0}, 1'b0);
			exec_check({OP_FCMPI, 10'h0}, i == 0);
		end
		finish_test("half_cmp");

		run_op(16'h1234, 16'hABCD, 16'h5A5A, {OP_R2, FN_XOR, 4'h0});
		apb_read(REG_A, got, err);
		check_value("A readback", got, 16'h1234);
		apb_read(REG_B, got, err);
		check_value("B readback", got, 16'hABCD);
		apb_read(REG_IMM, got, err);
		check_value("IMM readback", got, 16'h5A5A);
		apb_read(REG_IR, got, err);
		check_value("IR readback", got, {OP_R2, FN_XOR, 4'h0});
		apb_read(8'h18, got, err);
		check_value("pslverr on unmapped read", err, 16'h1);
		apb_write(REG_RESULT, 16'hFFFF, err);
		check_value("pslverr on RESULT write", err, 16'h1);
		apb_read(REG_RESULT, got, err);
		check_value("RESULT after refused write", got, 16'h1234 ^ 16'hABCD);
		apb_write(REG_STATUS, 16'h0001, err);
		check_value("pslverr on STATUS write", err, 16'h1);
		exec_check({6'h3F, 10'h0}, 1'b1);			// unknown opcode
		exec_check({OP_R2, FN_ADD, 4'h0}, 1'b1);	// clears the flag
		exec_check({OP_R2, 6'h3F, 4'h0}, 1'b1);		// unknown func
		exec_check({OP_R2, FN_R1, 4'hF}, 1'b1);		// unknown sub
		exec_check({OP_ADDI, 10'h0}, 1'b1);
		finish_test("regs");

		$display("tests done: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// run limit
	initial
	begin
		int cyc;
		cyc = 0;
		while (cyc < MAX_CYC)
		begin
			@(posedge clk_i);
			cyc++;
		end
		$display("timeout: tests did not finish within %0d cycles", MAX_CYC);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/phx_alu16_apb.sv
`timescale 1ns/1ps
`default_nettype none

module phx_alu16_apb import phx_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              psel_i,
	input  logic              penable_i,
	input  logic              pwrite_i,
	input  logic [APB_AW-1:0] paddr_i,
	input  logic [WORD_W-1:0] pwdata_i,
	output logic [WORD_W-1:0] prdata_o,
	output logic              pslverr_o
);

	logic [WORD_W-1:0] a_q, b_q, imm_q, ir_q;	// host written operands
	logic [WORD_W-1:0] res_q;
	logic              illegal_q;
	logic              busy_q;					// one cycle after the ir write
	logic [WORD_W-1:0] status_v;
	logic [WORD_W-1:0] alu_res;
	logic              alu_illegal;
	logic              acc;
	logic              addr_ok, addr_ro;
	logic              wr_en;

	// ============================================================
	// apb decode
	// ============================================================
	assign acc = psel_i & penable_i;			// access phase
	assign addr_ok = (paddr_i == REG_A) || (paddr_i == REG_B) || (paddr_i == REG_IMM)
		|| (paddr_i == REG_IR) || addr_ro;
	assign addr_ro = (paddr_i == REG_RESULT) || (paddr_i == REG_STATUS);
	assign pslverr_o = acc & (~addr_ok | (pwrite_i & addr_ro));
	assign wr_en = acc & pwrite_i & ~pslverr_o;	// error writes touch nothing

	// status word
	always_comb
	begin
		status_v = '0;
		status_v[ST_ILLEGAL] = illegal_q;
	end

	// read mux, only driven on a read access
	always_comb
	begin
		prdata_o = '0;
		if (acc && !pwrite_i)
		begin
			case (paddr_i)
			REG_A:		prdata_o = a_q;
			REG_B:		prdata_o = b_q;
			REG_IMM:	prdata_o = imm_q;
			REG_IR:		prdata_o = ir_q;
			REG_RESULT:	prdata_o = res_q;
			REG_STATUS:	prdata_o = status_v;
			default:	prdata_o = '0;
			endcase
		end
	end

	// ============================================================
	// registers
	// ============================================================
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			a_q <= '0;
			b_q <= '0;
			imm_q <= '0;
			ir_q <= '0;
			res_q <= '0;
			illegal_q <= 1'b0;
			busy_q <= 1'b0;
		end
		else
		begin
			busy_q <= wr_en && (paddr_i == REG_IR);	// launch on ir write
			if (wr_en)
			begin
				case (paddr_i)
				REG_A:		a_q <= pwdata_i;
				REG_B:		b_q <= pwdata_i;
				REG_IMM:	imm_q <= pwdata_i;
				REG_IR:		ir_q <= pwdata_i;
				default:	;
				endcase
			end
			if (busy_q)
			begin
				res_q <= alu_res;			// capture the settled alu output
				illegal_q <= alu_illegal;
			end
		end
	end

	phx_alu16 u_alu
	(
		.ir_i(ir_q),
		.a_i(a_q),
		.b_i(b_q),
		.imm_i(imm_q),
		.res_o(alu_res),
		.illegal_o(alu_illegal)
	);

	// bus protocol checks
	a_err_in_access : assert property (@(posedge clk_i) disable iff (rst_i)
		pslverr_o |-> (psel_i && penable_i))
		else $error("phx_alu16_apb: pslverr outside access phase");

	a_enable_sel : assert property (@(posedge clk_i) disable iff (rst_i)
		penable_i |-> psel_i)
		else $error("phx_alu16_apb: penable without psel");

endmodule

`default_nettype wire

// File: rtl/phx_alu16.sv
`timescale 1ns/1ps
`default_nettype none

module phx_alu16 import phx_pkg::*;
(
	input  logic [WORD_W-1:0] ir_i,
	input  logic [WORD_W-1:0] a_i,
	input  logic [WORD_W-1:0] b_i,
	input  logic [WORD_W-1:0] imm_i,
	output logic [WORD_W-1:0] res_o,
	output logic              illegal_o
);

	logic [OPC_W-1:0]  opc;
	logic [FN_W-1:0]   fn;
	logic [SB_W-1:0]   sb;
	int_op_t           int_op;
	fp_op_t            fp_op;
	logic              use_imm;		// fp compare operand select
	logic [WORD_W-1:0] int_b;		// B or IMM into the integer path
	logic [WORD_W-1:0] int_res, fp_res;

	assign opc = ir_i[OPC_LSB +: OPC_W];
	assign fn = ir_i[FN_LSB +: FN_W];
	assign sb = ir_i[SB_LSB +: SB_W];

	// ============================================================
	// decode
	// ============================================================
	always_comb
	begin
		int_op = INT_NONE;
		fp_op = FP_NONE;
		use_imm = 1'b0;
		int_b = b_i;
		case (opc)
		OP_R2:
			case (fn)
			FN_R1:
				case (sb)
				SB_CNTLZ:	int_op = INT_CNTLZ;
				SB_SEXTB:	int_op = INT_SEXTB;
				SB_FABS:	fp_op = FP_ABS;
				SB_FNABS:	fp_op = FP_NABS;
				SB_FNEG:	fp_op = FP_NEG;
				SB_FSIGN:	fp_op = FP_SIGN;
				SB_FFINITE:	fp_op = FP_FINITE;
				SB_FCLASS:	fp_op = FP_CLASS;
				default:	;		// unknown sub, illegal
				endcase
			FN_ADD:	int_op = INT_ADD;
			FN_SUB:	int_op = INT_SUB;
			FN_AND:	int_op = INT_AND;
			FN_OR:	int_op = INT_OR;
			FN_XOR:	int_op = INT_XOR;
			default:	;			// unknown func, illegal
			endcase
		OP_ADDI:
		begin
			int_op = INT_ADD;
			int_b = imm_i;
		end
		OP_SUBFI:	int_op = INT_RSUB;	// path reads imm itself
		OP_ANDI:
		begin
			int_op = INT_AND;
			int_b = imm_i;
		end
		OP_ORI:
		begin
			int_op = INT_OR;
			int_b = imm_i;
		end
		OP_XORI:
		begin
			int_op = INT_XOR;
			int_b = imm_i;
		end
		OP_CMP:		int_op = INT_CMP;
		OP_CMPI:
		begin
			int_op = INT_CMP;
			int_b = imm_i;		// compare against the immediate
		end
		OP_FCMP:	fp_op = FP_CMP;
		OP_FCMPI:
		begin
			fp_op = FP_CMP;
			use_imm = 1'b1;
		end
		default:	;			// unknown opcode, illegal
		endcase
	end

	phx_int_path16 u_int
	(
		.op_i(int_op),
		.a_i(a_i),
		.b_i(int_b),
		.imm_i(imm_i),
		.res_o(int_res)
	);

	phx_fp_path16 u_fp
	(
		.op_i(fp_op),
		.use_imm_i(use_imm),
		.a_i(a_i),
		.b_i(b_i),
		.imm_i(imm_i),
		.res_o(fp_res)
	);

	// result select, zero when nothing decoded
	assign illegal_o = (int_op == INT_NONE) && (fp_op == FP_NONE);
	assign res_o = illegal_o ? '0 : ((int_op != INT_NONE) ? int_res : fp_res);

	// decode must pick at most one path
	always_comb
	begin
		a_one_path : assert final (!((int_op != INT_NONE) && (fp_op != FP_NONE)))
			else $error("phx_alu16: both paths decoded for ir %h", ir_i);
	end

endmodule

`default_nettype wire

// File: rtl/phx_fp_path16.sv
`timescale 1ns/1ps
`default_nettype none

module phx_fp_path16 import phx_pkg::*;
(
	input  fp_op_t            op_i,
	input  logic              use_imm_i,	// compare against IMM instead of B
	input  logic [WORD_W-1:0] a_i,
	input  logic [WORD_W-1:0] b_i,
	input  logic [WORD_W-1:0] imm_i,
	output logic [WORD_W-1:0] res_o
);

	logic [WORD_W-1:0] cmp_b;
	logic [WORD_W-1:0] rel;
	logic [WORD_W-1:0] cls;
	logic [WORD_W-1:0] fsign_v;
	logic              sgn, xz, vz, inf, xinf, snan, qnan;

	assign cmp_b = use_imm_i ? imm_i : b_i;

	fp_decomp16 u_dec
	(
		.a_i(a_i),
		.sgn_o(sgn),
		.exp_o(),
		.man_o(),
		.xz_o(xz),
		.mz_o(),
		.vz_o(vz),
		.inf_o(inf),
		.xinf_o(xinf),
		.snan_o(snan),
		.qnan_o(qnan)
	);

	fp_compare16 u_cmp
	(
		.a_i(a_i),
		.b_i(cmp_b),
		.rel_o(rel)
	);

	// ============================================================
	// classify vector
	// ============================================================
	assign cls[0] = sgn & inf;			// -inf
	assign cls[1] = sgn;
	assign cls[2] = sgn & xz & ~vz;		// -subnormal
	assign cls[3] = sgn & vz;			// -0
	assign cls[4] = ~sgn & vz;			// +0
	assign cls[5] = ~sgn & xz & ~vz;	// +subnormal
	assign cls[6] = ~sgn;
	assign cls[7] = ~sgn & inf;			// +inf
	assign cls[8] = snan;
	assign cls[9] = qnan;
	assign cls[14:10] = '0;
	assign cls[15] = sgn;

	// sign of the value as a half, zero stays zero
	assign fsign_v = vz ? '0 : (sgn ? HALF_NEG_ONE : HALF_POS_ONE);

	always_comb
	begin
		case (op_i)
		FP_ABS:		res_o = {1'b0, a_i[WORD_W-2:0]};	// clear sign
		FP_NABS:	res_o = {1'b1, a_i[WORD_W-2:0]};	// force sign
		FP_NEG:		res_o = {~sgn, a_i[WORD_W-2:0]};
		FP_SIGN:	res_o = fsign_v;
		FP_FINITE:	res_o = {{(WORD_W-1){1'b0}}, ~xinf};
		FP_CLASS:	res_o = cls;
		FP_CMP:		res_o = rel;
		default:	res_o = '0;		// FP_NONE
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/phx_int_path16.sv
`timescale 1ns/1ps
`default_nettype none

module phx_int_path16 import phx_pkg::*;
(
	input  int_op_t           op_i,
	input  logic [WORD_W-1:0] a_i,
	input  logic [WORD_W-1:0] b_i,		// B, or IMM for immediate forms
	input  logic [WORD_W-1:0] imm_i,
	output logic [WORD_W-1:0] res_o
);

	logic [WORD_W-1:0] sum;
	logic [WORD_W-1:0] diff;
	logic [WORD_W-1:0] rdiff;
	logic [WORD_W-1:0] cmp_v;
	logic [WORD_W-1:0] sext_v;
	logic [CLZ_W-1:0]  clz_n;
	logic              found;

	// ============================================================
	// adder and subtracters
	// ============================================================
	assign sum = a_i + b_i;
	assign diff = a_i - b_i;
	assign rdiff = imm_i - a_i;		// subfi takes the immediate directly

	// compare vector, signed and unsigned sets
	always_comb
	begin
		cmp_v = '0;
		cmp_v[0] = a_i == b_i;
		cmp_v[1] = $signed(a_i) < $signed(b_i);
		cmp_v[2] = $signed(a_i) <= $signed(b_i);
		cmp_v[5] = a_i < b_i;		// unsigned
		cmp_v[6] = a_i <= b_i;
		cmp_v[8] = a_i != b_i;
		cmp_v[9] = $signed(a_i) >= $signed(b_i);
		cmp_v[10] = $signed(a_i) > $signed(b_i);
		cmp_v[13] = a_i >= b_i;
		cmp_v[14] = a_i > b_i;
	end

	// leading zeros, first set bit from the top wins
	always_comb
	begin
		clz_n = CLZ_W'(WORD_W);		// all zero gives 16
		found = 1'b0;
		for (int i = WORD_W-1; i >= 0; i--)
		begin
			if (a_i[i] && !found)
			begin
				clz_n = CLZ_W'(WORD_W-1-i);
				found = 1'b1;
			end
		end
	end

	assign sext_v = {{(WORD_W-8){a_i[7]}}, a_i[7:0]};	// low byte, sign filled

	// ============================================================
	// result select
	// ============================================================
	always_comb
	begin
		case (op_i)
		INT_ADD:	res_o = sum;
		INT_SUB:	res_o = diff;
		INT_RSUB:	res_o = rdiff;
		INT_AND:	res_o = a_i & b_i;
		INT_OR:		res_o = a_i | b_i;
		INT_XOR:	res_o = a_i ^ b_i;
		INT_CMP:	res_o = cmp_v;
		INT_CNTLZ:	res_o = {{(WORD_W-CLZ_W){1'b0}}, clz_n};
		INT_SEXTB:	res_o = sext_v;
		default:	res_o = '0;		// INT_NONE
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/fp_compare16.sv
`timescale 1ns/1ps
`default_nettype none

module fp_compare16
(
	input  logic [15:0] a_i,
	input  logic [15:0] b_i,
	output logic [15:0] rel_o
);

	logic        a_sgn, b_sgn;
	logic        a_vz, b_vz;
	logic        a_snan, a_qnan, b_snan, b_qnan;
	logic [14:0] mag_a, mag_b;
	logic        unord, both_z;
	logic        eq_raw, lt_raw;
	logic        eq, lt;

	fp_decomp16 u_dec_a
	(
		.a_i(a_i),
		.sgn_o(a_sgn),
		.exp_o(),
		.man_o(),
		.xz_o(),
		.mz_o(),
		.vz_o(a_vz),
		.inf_o(),
		.xinf_o(),
		.snan_o(a_snan),
		.qnan_o(a_qnan)
	);

	fp_decomp16 u_dec_b
	(
		.a_i(b_i),
		.sgn_o(b_sgn),
		.exp_o(),
		.man_o(),
		.xz_o(),
		.mz_o(),
		.vz_o(b_vz),
		.inf_o(),
		.xinf_o(),
		.snan_o(b_snan),
		.qnan_o(b_qnan)
	);

	assign mag_a = a_i[14:0];
	assign mag_b = b_i[14:0];
	assign unord = a_snan | a_qnan | b_snan | b_qnan;	// any nan breaks ordering
	assign both_z = a_vz & b_vz;						// +0 == -0

	// sign-magnitude ordering, ignoring nan
	assign eq_raw = both_z | (a_i == b_i);
	always_comb
	begin
		if (both_z)
			lt_raw = 1'b0;
		else if (a_sgn != b_sgn)
			lt_raw = a_sgn;					// negative side is smaller
		else if (a_sgn)
			lt_raw = mag_a > mag_b;			// both negative, larger magnitude is less
		else
			lt_raw = mag_a < mag_b;
	end

	assign eq = ~unord & eq_raw;
	assign lt = ~unord & lt_raw;

	always_comb
	begin
		rel_o = '0;
		rel_o[0] = eq;
		rel_o[1] = lt;
		rel_o[2] = lt | eq;
		rel_o[4] = unord;
		rel_o[5] = ~eq;							// also set when unordered
		rel_o[9] = ~unord & ~lt_raw;				// >=
		rel_o[10] = ~unord & ~lt_raw & ~eq_raw;	// >
		rel_o[11] = mag_a >= mag_b;				// magnitude only
		rel_o[12] = ~unord;
	end

	// ordering sanity, checked once the inputs settle
	always_comb
	begin
		a_eq_lt : assert final (!(rel_o[0] && rel_o[1]))
			else $error("fp_compare16: equal and less both set");
	end

endmodule

`default_nettype wire

// File: rtl/fp_decomp16.sv
`timescale 1ns/1ps
`default_nettype none

module fp_decomp16
(
	input  logic [15:0] a_i,
	output logic        sgn_o,
	output logic [4:0]  exp_o,
	output logic [9:0]  man_o,
	output logic        xz_o,		// exponent all zero
	output logic        mz_o,		// mantissa all zero
	output logic        vz_o,		// value is +/-0
	output logic        inf_o,		// +/- infinity
	output logic        xinf_o,		// exponent all ones
	output logic        snan_o,
	output logic        qnan_o
);

	// field split
	assign sgn_o = a_i[15];
	assign exp_o = a_i[14:10];
	assign man_o = a_i[9:0];

	// exponent and mantissa extremes
	assign xz_o = ~|exp_o;
	assign xinf_o = &exp_o;
	assign mz_o = ~|man_o;

	// special kinds
	assign vz_o = xz_o & mz_o;				// zero, either sign
	assign inf_o = xinf_o & mz_o;			// max exponent, empty mantissa
	assign qnan_o = xinf_o & man_o[9];		// top mantissa bit marks quiet
	assign snan_o = xinf_o & ~man_o[9] & ~mz_o;	// nan without the quiet bit

endmodule

`default_nettype wire

// File: rtl/phx_pkg.sv
`default_nettype none

package phx_pkg;

	// ============================================================
	// datapath widths
	// ============================================================
	localparam int WORD_W = 16;		// scalar data width
	localparam int CLZ_W = 5;		// leading zero count, 0..16
	localparam int APB_AW = 8;		// apb byte address width

	// instruction word layout: opcode | func | sub
	localparam int OPC_LSB = 10;
	localparam int OPC_W = 6;
	localparam int FN_LSB = 4;
	localparam int FN_W = 6;
	localparam int SB_LSB = 0;
	localparam int SB_W = 4;

	// ============================================================
	// opcodes
	// ============================================================
	localparam logic [OPC_W-1:0] OP_R2 = 6'd2;		// reg-reg group, func decides
	localparam logic [OPC_W-1:0] OP_ADDI = 6'd4;
	localparam logic [OPC_W-1:0] OP_SUBFI = 6'd5;	// imm - a
	localparam logic [OPC_W-1:0] OP_ANDI = 6'd8;
	localparam logic [OPC_W-1:0] OP_ORI = 6'd9;
	localparam logic [OPC_W-1:0] OP_XORI = 6'd10;
	localparam logic [OPC_W-1:0] OP_CMP = 6'd12;
	localparam logic [OPC_W-1:0] OP_CMPI = 6'd13;
	localparam logic [OPC_W-1:0] OP_FCMP = 6'd14;
	localparam logic [OPC_W-1:0] OP_FCMPI = 6'd15;

	// func codes under OP_R2
	localparam logic [FN_W-1:0] FN_R1 = 6'd1;		// one operand group, sub decides
	localparam logic [FN_W-1:0] FN_ADD = 6'd4;
	localparam logic [FN_W-1:0] FN_SUB = 6'd5;
	localparam logic [FN_W-1:0] FN_AND = 6'd8;
	localparam logic [FN_W-1:0] FN_OR = 6'd9;
	localparam logic [FN_W-1:0] FN_XOR = 6'd10;

	// sub codes under FN_R1
	localparam logic [SB_W-1:0] SB_CNTLZ = 4'd0;
	localparam logic [SB_W-1:0] SB_SEXTB = 4'd1;
	localparam logic [SB_W-1:0] SB_FABS = 4'd2;
	localparam logic [SB_W-1:0] SB_FNABS = 4'd3;
	localparam logic [SB_W-1:0] SB_FNEG = 4'd4;
	localparam logic [SB_W-1:0] SB_FSIGN = 4'd5;
	localparam logic [SB_W-1:0] SB_FFINITE = 4'd6;
	localparam logic [SB_W-1:0] SB_FCLASS = 4'd7;

	// ============================================================
	// decoded operations, one enum per path
	// ============================================================
	typedef enum logic [3:0] {
		INT_NONE,
		INT_ADD,
		INT_SUB,
		INT_RSUB,		// imm - a
		INT_AND,
		INT_OR,
		INT_XOR,
		INT_CMP,
		INT_CNTLZ,
		INT_SEXTB
	} int_op_t;

	typedef enum logic [2:0] {
		FP_NONE,
		FP_ABS,
		FP_NABS,
		FP_NEG,
		FP_SIGN,
		FP_FINITE,
		FP_CLASS,
		FP_CMP
	} fp_op_t;

	// binary16 constants
	localparam logic [WORD_W-1:0] HALF_POS_ONE = 16'h3C00;
	localparam logic [WORD_W-1:0] HALF_NEG_ONE = 16'hBC00;

	// register map, byte offsets
	localparam logic [APB_AW-1:0] REG_A = 8'h00;
	localparam logic [APB_AW-1:0] REG_B = 8'h04;
	localparam logic [APB_AW-1:0] REG_IMM = 8'h08;
	localparam logic [APB_AW-1:0] REG_IR = 8'h0C;		// write launches
	localparam logic [APB_AW-1:0] REG_RESULT = 8'h10;	// read only
	localparam logic [APB_AW-1:0] REG_STATUS = 8'h14;	// read only
	localparam int ST_ILLEGAL = 0;						// status bit, illegal instruction

endpackage

`default_nettype wire
